/* Makefile */
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_exec --Mdir $(OBJ_DIR) -f build.f

run: compile
	./$(OBJ_DIR)/Vtb_exec > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation stopped early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
rtl/rv_exec_pkg.sv
rtl/alu_core.sv
rtl/seq_mul.sv
rtl/exec_cfg.sv
rtl/exec_ctrl.sv
rtl/exec_top.sv
tests/clk_gen.sv
tests/exec_assert.sv
tests/tb_exec.sv

/* rtl/alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_core #(
    parameter int XLEN = rv_exec_pkg::xlen
) (
    input  wire rv_exec_pkg::alu_op_t op,
    input  wire [XLEN-1:0]            src1,
    input  wire [XLEN-1:0]            src2,
    output logic [XLEN-1:0]           alu_res,
    output logic                      cmp_flag
);
    import rv_exec_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;     // full width shift amount
    logic [4:0]     shamt_w;   // word shift amount
    logic [31:0]    word_res;
    logic           eq;
    logic           lt_s;
    logic           lt_u;

    assign shamt   = src2[SHW-1:0];
    assign shamt_w = src2[4:0];

    // shared compare terms for slt and branches
    assign eq   = (src1 == src2);
    assign lt_s = ($signed(src1) < $signed(src2));
    assign lt_u = (src1 < src2);

    always_comb begin
        alu_res  = '0;
        cmp_flag = 1'b0;
        word_res = '0;
        case (op)
            op_add: alu_res = src1 + src2;
            op_sub: alu_res = src1 - src2;
            op_and: alu_res = src1 & src2;
            op_or:  alu_res = src1 | src2;
            op_xor: alu_res = src1 ^ src2;

            op_sll: alu_res = src1 << shamt;
            op_srl: alu_res = src1 >> shamt;
            op_sra: alu_res = $signed(src1) >>> shamt;

            // word shifts, result zero-extended here
            // sign extension is up to the ext code
            op_sllw: begin
                word_res = src1[31:0] << shamt_w;
                alu_res  = {{(XLEN-32){1'b0}}, word_res};
            end
            op_srlw: begin
                word_res = src1[31:0] >> shamt_w;
                alu_res  = {{(XLEN-32){1'b0}}, word_res};
            end
            op_sraw: begin
                word_res = $signed(src1[31:0]) >>> shamt_w;
                alu_res  = {{(XLEN-32){1'b0}}, word_res};
            end

            op_slt:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
            op_sltu: alu_res = {{(XLEN-1){1'b0}}, lt_u};

            // branches: flag set when taken, result stays zero
            op_beq:  cmp_flag = eq;
            op_bne:  cmp_flag = !eq;
            op_blt:  cmp_flag = lt_s;
            op_bge:  cmp_flag = !lt_s;
            op_bltu: cmp_flag = lt_u;
            op_bgeu: cmp_flag = !lt_u;

            default: begin
                alu_res  = '0;  // mul ops, handled by seq_mul
                cmp_flag = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/exec_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_cfg (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    cfg_we,
    input  wire                    cfg_addr,
    input  wire  [31:0]            cfg_wdata,
    output logic [31:0]            cfg_rdata,
    input  wire                    op_done,
    output rv_exec_pkg::mul_mode_t mul_mode
);
    import rv_exec_pkg::*;

    logic [31:0] op_count;  // completed ops, wraps
    logic        wr_mode;
    logic        wr_count;

    assign wr_mode  = cfg_we && (cfg_addr == cfg_addr_mode);
    assign wr_count = cfg_we && (cfg_addr == cfg_addr_count);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mul_mode <= mode_ss;
        else if (wr_mode)
            mul_mode <= mul_mode_t'(cfg_wdata[1:0]);
    end

    // any write to the count address clears it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            op_count <= '0;
        else if (wr_count)
            op_count <= '0;
        else if (op_done)
            op_count <= op_count + 32'd1;
    end

    assign cfg_rdata = (cfg_addr == cfg_addr_mode) ? {30'd0, mul_mode} : op_count;

endmodule

`default_nettype wire

/* rtl/exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl #(
    parameter int XLEN = rv_exec_pkg::xlen
) (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     req,
    input  wire rv_exec_pkg::alu_op_t op,
    input  wire  [XLEN-1:0]         src1,
    input  wire  [XLEN-1:0]         src2,
    input  wire rv_exec_pkg::ext_t  ext,
    output logic                    ack,
    output logic [XLEN-1:0]         res,
    output logic                    cmp_flag,
    output rv_exec_pkg::alu_op_t    lat_op,
    output logic [XLEN-1:0]         lat_src1,
    output logic [XLEN-1:0]         lat_src2,
    input  wire  [XLEN-1:0]         alu_res,
    input  wire                     alu_cmp,
    output logic                    mul_start,
    output logic                    src1_signed,
    output logic                    src2_signed,
    input  wire                     mul_done,
    input  wire  [2*XLEN-1:0]       product,
    input  wire rv_exec_pkg::mul_mode_t mul_mode,
    output logic                    op_done
);
    import rv_exec_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_exec, st_mul_wait, st_hold, st_release
    } state_t;

    state_t          state;
    ext_t            lat_ext;
    mul_mode_t       lat_mode;   // mode frozen at latch time
    logic            take_req;
    logic            is_mul;
    logic            finish;
    logic [XLEN-1:0] raw_res;
    logic [XLEN-1:0] ext_res;

    // release takes a new req straight away, ack is already low there
    assign take_req = req && (state == st_idle || state == st_release);
    assign is_mul   = (lat_op == op_mul) || (lat_op == op_mulh);
    assign finish   = (state == st_exec && !is_mul) || (state == st_mul_wait && mul_done);

    // low half of the product is the same for any signedness
    always_comb begin
        src1_signed = 1'b0;
        src2_signed = 1'b0;
        if (lat_op == op_mulh) begin
            case (lat_mode)
                mode_ss: begin
                    src1_signed = 1'b1;
                    src2_signed = 1'b1;
                end
                mode_su: src1_signed = 1'b1;
                default: src1_signed = 1'b0;  // uu and value 3
            endcase
        end
    end

    always_comb begin
        case (lat_op)
            op_mul:  raw_res = product[XLEN-1:0];
            op_mulh: raw_res = product[2*XLEN-1:XLEN];
            default: raw_res = alu_res;
        endcase
    end

    always_comb begin
        case (lat_ext)
            ext_w_sign: ext_res = {{(XLEN-32){raw_res[31]}}, raw_res[31:0]};
            ext_w_zero: ext_res = {{(XLEN-32){1'b0}}, raw_res[31:0]};
            ext_h_sign: ext_res = {{(XLEN-16){raw_res[15]}}, raw_res[15:0]};
            default:    ext_res = raw_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            lat_op   <= op;
            lat_src1 <= src1;
            lat_src2 <= src2;
            lat_ext  <= ext;
            lat_mode <= mul_mode;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            ack       <= 1'b0;
            res       <= '0;
            cmp_flag  <= 1'b0;
            mul_start <= 1'b0;
            op_done   <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            op_done   <= 1'b0;
            if (finish) begin
                res      <= ext_res;
                cmp_flag <= alu_cmp;  // low for mul ops
                ack      <= 1'b1;
                op_done  <= 1'b1;
            end
            case (state)
                st_idle, st_release: state <= take_req ? st_exec : st_idle;
                st_exec: begin
                    mul_start <= is_mul;
                    state     <= is_mul ? st_mul_wait : st_hold;
                end
                st_mul_wait: if (mul_done) state <= st_hold;
                st_hold: begin
                    if (!req) begin  // requester let go
                        ack   <= 1'b0;
                        state <= st_release;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
    parameter int XLEN = rv_exec_pkg::xlen
) (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       req,
    input  wire rv_exec_pkg::alu_op_t op,
    input  wire  [XLEN-1:0]           src1,
    input  wire  [XLEN-1:0]           src2,
    input  wire rv_exec_pkg::ext_t    ext,
    output logic                      ack,
    output logic [XLEN-1:0]           res,
    output logic                      cmp_flag,
    input  wire                       cfg_we,
    input  wire                       cfg_addr,
    input  wire  [31:0]               cfg_wdata,
    output logic [31:0]               cfg_rdata
);
    import rv_exec_pkg::*;

    alu_op_t           lat_op;
    logic [XLEN-1:0]   lat_src1;
    logic [XLEN-1:0]   lat_src2;
    logic [XLEN-1:0]   alu_res;
    logic              alu_cmp;
    logic              mul_start;
    logic              src1_signed;
    logic              src2_signed;
    logic              mul_done;
    logic [2*XLEN-1:0] product;
    mul_mode_t         mul_mode;
    logic              op_done;

    exec_ctrl #(.XLEN(XLEN)) u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .op          (op),
        .src1        (src1),
        .src2        (src2),
        .ext         (ext),
        .ack         (ack),
        .res         (res),
        .cmp_flag    (cmp_flag),
        .lat_op      (lat_op),
        .lat_src1    (lat_src1),
        .lat_src2    (lat_src2),
        .alu_res     (alu_res),
        .alu_cmp     (alu_cmp),
        .mul_start   (mul_start),
        .src1_signed (src1_signed),
        .src2_signed (src2_signed),
        .mul_done    (mul_done),
        .product     (product),
        .mul_mode    (mul_mode),
        .op_done     (op_done)
    );

    alu_core #(.XLEN(XLEN)) u_alu (
        .op       (lat_op),
        .src1     (lat_src1),
        .src2     (lat_src2),
        .alu_res  (alu_res),
        .cmp_flag (alu_cmp)
    );

    // multiplier sees the latched operands too
    seq_mul #(.XLEN(XLEN)) u_mul (
        .clk         (clk),
        .arst_n      (arst_n),
        .mul_start   (mul_start),
        .src1        (lat_src1),
        .src2        (lat_src2),
        .src1_signed (src1_signed),
        .src2_signed (src2_signed),
        .busy        (),
        .mul_done    (mul_done),
        .product     (product)
    );

    exec_cfg u_cfg (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .op_done   (op_done),
        .mul_mode  (mul_mode)
    );

endmodule

`default_nettype wire

/* rtl/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

    localparam int xlen = 64;  // default data width

    // operation codes seen by the execute stage
    typedef enum logic [4:0] {
        op_add   = 5'd0,
        op_sub   = 5'd1,
        op_and   = 5'd2,
        op_or    = 5'd3,
        op_xor   = 5'd4,
        op_sll   = 5'd5,
        op_srl   = 5'd6,
        op_sra   = 5'd7,
        op_sllw  = 5'd8,   // word shifts work on the low 32 bits
        op_srlw  = 5'd9,
        op_sraw  = 5'd10,
        op_slt   = 5'd11,
        op_sltu  = 5'd12,
        op_beq   = 5'd13,
        op_bne   = 5'd14,
        op_blt   = 5'd15,
        op_bge   = 5'd16,
        op_bltu  = 5'd17,
        op_bgeu  = 5'd18,
        op_mul   = 5'd19,  // low half of product
        op_mulh  = 5'd20   // high half, signedness from mode reg
    } alu_op_t;

    typedef enum logic [1:0] {
        ext_none   = 2'd0,
        ext_w_sign = 2'd1,  // from bit 31
        ext_w_zero = 2'd2,
        ext_h_sign = 2'd3   // from bit 15
    } ext_t;

    // operand signedness for mulh, 3 acts like uu
    typedef enum logic [1:0] {
        mode_ss = 2'd0,
        mode_su = 2'd1,
        mode_uu = 2'd2
    } mul_mode_t;

    localparam logic cfg_addr_mode  = 1'b0;
    localparam logic cfg_addr_count = 1'b1;

endpackage

`default_nettype wire

/* rtl/seq_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_mul #(
    parameter int XLEN = rv_exec_pkg::xlen
) (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 mul_start,
    input  wire  [XLEN-1:0]     src1,         // multiplicand
    input  wire  [XLEN-1:0]     src2,         // multiplier
    input  wire                 src1_signed,
    input  wire                 src2_signed,
    output logic                busy,
    output logic                mul_done,
    output logic [2*XLEN-1:0]   product
);
    localparam int CW = $clog2(XLEN);

    logic [CW-1:0]     cnt;            // multiplier bit in work
    logic [2*XLEN-1:0] mcand;          // shifted left each step
    logic [XLEN-1:0]   mplier;         // shifted right each step
    logic              mplier_signed;
    logic              start_ok;
    logic              last_step;

    assign start_ok  = mul_start && !busy;
    assign last_step = (cnt == CW'(XLEN - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            mul_done <= 1'b0;
            cnt      <= '0;
        end else begin
            mul_done <= 1'b0;
            if (start_ok) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last_step) begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;  // product valid with this pulse
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            mcand         <= src1_signed ? {{XLEN{src1[XLEN-1]}}, src1}
                                         : {{XLEN{1'b0}}, src1};
            mplier        <= src2;
            mplier_signed <= src2_signed;
            product       <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                // top bit of a signed multiplier carries negative weight
                if (last_step && mplier_signed)
                    product <= product - mcand;
                else
                    product <= product + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

`default_nettype wire

/* tests/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/exec_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_assert (
    input wire clk,
    input wire arst_n,
    input wire req,
    input wire ack,
    input wire mul_start
);

    // first edge out of reset must see ack low
    ack_low_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !ack)
        else $error("ack high when reset was released");

    ack_rise_with_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a request");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    mul_start_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        mul_start |=> !mul_start)
        else $error("mul_start held for more than one cycle");

endmodule

bind exec_ctrl exec_assert u_exec_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .ack       (ack),
    .mul_start (mul_start)
);

`default_nettype wire

/* tests/tb_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec;
    import rv_exec_pkg::*;

    localparam int XLEN = xlen;
    localparam int cycle_limit = 400 * (XLEN + 8) + 2000;  // op budget plus margin

    logic            clk;
    logic            arst_n;
    logic            req;
    alu_op_t         op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    ext_t            ext;
    logic            ack;
    logic [XLEN-1:0] res;
    logic            cmp_flag;
    logic            cfg_we;
    logic            cfg_addr;
    logic [31:0]     cfg_wdata;
    logic [31:0]     cfg_rdata;

    logic [1:0]  cur_mode;  // last mode written
    int          res_errs = 0;
    int          flag_errs = 0;
    int          hs_errs = 0;
    int          cfg_errs = 0;
    int          cycles = 0;

    clk_gen u_clk (.clk(clk), .arst_n(arst_n));

    exec_top #(.XLEN(XLEN)) DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .op        (op),
        .src1      (src1),
        .src2      (src2),
        .ext       (ext),
        .ack       (ack),
        .res       (res),
        .cmp_flag  (cmp_flag),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("cycle limit of %0d reached before the tests completed", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // expected result and flag from the op and extension rules
    function automatic void ref_model(
        input  alu_op_t         o,
        input  logic [XLEN-1:0] a,
        input  logic [XLEN-1:0] b,
        input  ext_t            e,
        input  logic [1:0]      mode,
        output logic [XLEN-1:0] r,
        output logic            f
    );
        logic [XLEN-1:0]   raw;
        logic [2*XLEN-1:0] wa;
        logic [2*XLEN-1:0] wb;
        logic [2*XLEN-1:0] prod;
        logic              sa;
        logic              sb;
        raw  = '0;
        f    = 1'b0;
        sa   = (o == op_mulh) && (mode == 2'd0 || mode == 2'd1);
        sb   = (o == op_mulh) && (mode == 2'd0);
        wa   = sa ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        wb   = sb ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        prod = wa * wb;  // low 128 bits of the full product
        case (o)
            op_add:  raw = a + b;
            op_sub:  raw = a - b;
            op_and:  raw = a & b;
            op_or:   raw = a | b;
            op_xor:  raw = a ^ b;
            op_sll:  raw = a << b[5:0];
            op_srl:  raw = a >> b[5:0];
            op_sra:  raw = $signed(a) >>> b[5:0];
            op_sllw: raw = {{(XLEN-32){1'b0}}, a[31:0] << b[4:0]};
            op_srlw: raw = {{(XLEN-32){1'b0}}, a[31:0] >> b[4:0]};
            op_sraw: raw = {{(XLEN-32){1'b0}}, 32'($signed(a[31:0]) >>> b[4:0])};
            op_slt:  raw = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            op_sltu: raw = (a < b) ? 64'd1 : 64'd0;
            op_beq:  f = (a == b);
            op_bne:  f = (a != b);
            op_blt:  f = ($signed(a) < $signed(b));
            op_bge:  f = ($signed(a) >= $signed(b));
            op_bltu: f = (a < b);
            op_bgeu: f = (a >= b);
            op_mul:  raw = prod[XLEN-1:0];
            op_mulh: raw = prod[2*XLEN-1:XLEN];
            default: raw = '0;
        endcase
        case (e)
            ext_w_sign: r = {{(XLEN-32){raw[31]}}, raw[31:0]};
            ext_w_zero: r = {{(XLEN-32){1'b0}}, raw[31:0]};
            ext_h_sign: r = {{(XLEN-16){raw[15]}}, raw[15:0]};
            default:    r = raw;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    // values near zero and the sign boundary
    function automatic logic [XLEN-1:0] edge_word();
        case ($urandom_range(5, 0))
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(XLEN-1){1'b0}}};
            3:       return {1'b0, {(XLEN-1){1'b1}}};
            4:       return -XLEN'($urandom_range(100, 1));
            default: return rand_word();
        endcase
    endfunction

    // one four-phase transfer entered 1 ns after a rising edge with ack low
    task automatic run_op(input alu_op_t o, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input ext_t e);
        logic [XLEN-1:0] exp_r;
        logic [XLEN-1:0] held_r;
        logic            exp_f;
        logic            held_f;
        int              waited;
        int              extra;
        ref_model(o, a, b, e, cur_mode, exp_r, exp_f);
        waited = 0;
        extra  = $urandom_range(3, 0);
        op     = o;
        src1   = a;
        src2   = b;
        ext    = e;
        req    = 1'b1;
        while (!ack) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (o != op_mul && o != op_mulh) begin
            assert (waited == 2) else begin
                hs_errs++;
                $display("ERR %0t: %s acked after %0d edges, expected 2",
                         $time, o.name(), waited);
            end
        end
        assert (res == exp_r) else begin
            res_errs++;
            $display("ERR %0t: %s a=%h b=%h ext=%0d res=%h expected %h",
                     $time, o.name(), a, b, e, res, exp_r);
        end
        assert (cmp_flag == exp_f) else begin
            flag_errs++;
            $display("ERR %0t: %s a=%h b=%h cmp_flag=%b expected %b",
                     $time, o.name(), a, b, cmp_flag, exp_f);
        end
        held_r = res;
        held_f = cmp_flag;
        repeat (extra) begin  // requester stalls while outputs hold
            @(posedge clk);
            #1;
            assert (ack && res == held_r && cmp_flag == held_f) else begin
                hs_errs++;
                $display("ERR %0t: ack or result changed while req was held", $time);
            end
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        assert (!ack) else begin
            hs_errs++;
            $display("ERR %0t: ack still high one edge after req fell", $time);
        end
    endtask

    task automatic cfg_write(input logic addr, input logic [31:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic cfg_check(input logic addr, input logic [31:0] expected);
        cfg_addr = addr;
        #2;
        assert (cfg_rdata == expected) else begin
            cfg_errs++;
            $display("ERR %0t: cfg read at address %0d gave %0d, expected %0d",
                     $time, addr, cfg_rdata, expected);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        alu_op_t         o;
        ext_t            e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              n_ops;
        int              total;
        void'($urandom(32'hac45f510));
        req       = 1'b0;
        op        = op_add;
        src1      = '0;
        src2      = '0;
        ext       = ext_none;
        cfg_we    = 1'b0;
        cfg_addr  = 1'b0;
        cfg_wdata = '0;
        cur_mode  = 2'd0;
        @(posedge arst_n);
        @(posedge clk);
        #1;
        cfg_check(cfg_addr_mode, 32'd0);
        cfg_check(cfg_addr_count, 32'd0);

        // random alu ops with random extension
        repeat (150) begin
            o = alu_op_t'(5'($urandom_range(18, 0)));
            e = ext_t'(2'($urandom_range(3, 0)));
            run_op(o, rand_word(), rand_word(), e);
        end

        // compares and slt with operands often equal or at the sign boundary
        repeat (100) begin
            o = alu_op_t'(5'($urandom_range(18, 11)));
            a = edge_word();
            b = ($urandom_range(1, 0) == 1) ? a : edge_word();
            run_op(o, a, b, ext_none);
        end

        // multiplies under every mode value including 3
        for (int m = 0; m < 4; m++) begin
            cfg_write(cfg_addr_mode, m);
            cur_mode = 2'(m);
            cfg_check(cfg_addr_mode, m);
            repeat (25) begin
                o = ($urandom_range(1, 0) == 1) ? op_mulh : op_mul;
                e = ext_t'(2'($urandom_range(3, 0)));
                a = ($urandom_range(1, 0) == 1) ? edge_word() : rand_word();
                b = ($urandom_range(1, 0) == 1) ? edge_word() : rand_word();
                run_op(o, a, b, e);
            end
        end

        // op counter after a clear
        cfg_write(cfg_addr_count, 32'd0);
        n_ops = $urandom_range(30, 10);
        repeat (n_ops) begin
            o = alu_op_t'(5'($urandom_range(18, 0)));
            run_op(o, rand_word(), rand_word(), ext_none);
        end
        cfg_check(cfg_addr_count, n_ops);
        cfg_check(cfg_addr_mode, 32'(cur_mode));

        total = res_errs + flag_errs + hs_errs + cfg_errs;
        $display("errors: result %0d, flag %0d, handshake %0d, config %0d",
                 res_errs, flag_errs, hs_errs, cfg_errs);
        if (total == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
